//--- design/boardLinkRx.sv
`timescale 1ns/1ps

`include "checkers_consts.svh"

module boardLinkRx (
	input logic rst,
	input logic newData,
	input logic linkClkIn,
	input logic linkDataIn,
	input logic linkFrameIn,
	output logic rxValid,
	output checkersPkg::boardWord rxBoard
);
	import checkersPkg::*;

	localparam int BITS = `BOARD_BITS;
	localparam int CNT_BITS = $clog2(`BOARD_BITS);

	boardWord shiftReg;
	logic [CNT_BITS-1:0] bitCnt;
	logic clkPrev; // line clock one cycle ago
	logic rise;
	logic take; // rising edge inside a frame

	// same clock domain as the sender, edge detect only
	assign rise = linkClkIn & ~clkPrev;
	assign take = rise & linkFrameIn;

	assign rxBoard = shiftReg; // complete while rxValid is high

	always_ff @(posedge rst or posedge newData) begin
		if (newData) begin
			clkPrev <= 1'b0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end else begin
			clkPrev <= linkClkIn;
			// strobe on the edge carrying bit 0
			rxValid <= take && (bitCnt == CNT_BITS'(BITS - 1));
			if (!linkFrameIn)
				bitCnt <= '0; // idle line, restart
			else if (rise)
				bitCnt <= bitCnt + 1'b1; // wraps to 0 after 256
		end
	end

	// msb first, so the first bit ends up at 255
	always_ff @(posedge rst) begin
		if (take)
			shiftReg <= (shiftReg << 1) | BITS'(linkDataIn);
	end

endmodule

//--- design/boardLinkTx.sv
`timescale 1ns/1ps

`include "checkers_consts.svh"

module boardLinkTx (
	input logic rst,
	input logic newData,
	input logic sendValid,
	input checkersPkg::boardWord sendBoard,
	output logic sendReady,
	output logic linkClkOut,
	output logic linkDataOut,
	output logic linkFrameOut
);
	import checkersPkg::*;

	localparam int CNT_BITS = $clog2(`BOARD_BITS);
	localparam int ROW_BITS = `BOARD_BITS / `BOARD_ROWS;

	boardWord shiftReg; // msb is the bit on the line
	logic [CNT_BITS-1:0] bitCnt;
	logic phase; // 0 = clock low half, 1 = clock high half
	logic frame;
	logic drain; // one extra busy cycle after the frame
	logic accept;
	logic lastBit;

	assign accept = sendValid & sendReady;
	assign lastBit = (bitCnt == CNT_BITS'(`BOARD_BITS - 1));

	// line drive
	assign linkClkOut = phase;
	assign linkFrameOut = frame;
	assign linkDataOut = frame & shiftReg.rows[`BOARD_ROWS-1][ROW_BITS-1]; // idle low

	always_ff @(posedge rst or posedge newData) begin
		if (newData) begin
			frame <= 1'b0;
			phase <= 1'b0;
			drain <= 1'b0;
			bitCnt <= '0;
			sendReady <= 1'b1;
		end else if (accept) begin
			frame <= 1'b1; // frame up on the next cycle
			phase <= 1'b0; // bit 255 goes out with clock low
			bitCnt <= '0;
			sendReady <= 1'b0;
		end else begin
			// ready follows busy one cycle late, 514 low cycles in all
			sendReady <= ~(frame | drain);
			drain <= 1'b0;
			if (frame) begin
				if (!phase) begin
					phase <= 1'b1; // rising edge, rx samples here
				end else begin
					phase <= 1'b0;
					if (lastBit) begin
						frame <= 1'b0; // clock and frame drop together
						drain <= 1'b1;
					end else begin
						bitCnt <= bitCnt + 1'b1;
					end
				end
			end
		end
	end

	// payload, moves one bit after each high half
	always_ff @(posedge rst) begin
		if (accept)
			shiftReg <= sendBoard;
		else if (frame && phase)
			shiftReg <= shiftReg << 1;
	end

endmodule

//--- design/boardRender.sv
`timescale 1ns/1ps

`include "checkers_consts.svh"

module boardRender (
	input logic rst,
	input logic newData,
	input logic [9:0] pixelX,
	input logic [8:0] pixelY,
	input checkersPkg::boardWord displayBoard,
	output logic [23:0] pixelColor
);
	import checkersPkg::*;

	localparam int POS_BITS = $clog2(`BOARD_ROWS); // row or column index
	localparam int SQ_PIX = 1 << `SQUARE_SHIFT;
	localparam int BOARD_PIX = `BOARD_ROWS * SQ_PIX;
	localparam int CTR_LO = SQ_PIX / 4; // king mark is the middle half
	localparam int CTR_HI = SQ_PIX - CTR_LO;

	logic [9:0] relX;
	logic [8:0] relY;
	logic inBoard;
	logic [POS_BITS-1:0] col;
	logic [POS_BITS-1:0] row;
	logic [`SQUARE_SHIFT-1:0] offX; // position inside the square
	logic [`SQUARE_SHIFT-1:0] offY;
	logic centre;
	squareCode sq;
	logic [23:0] baseColor;
	logic [23:0] nextColor;

	// board relative position
	assign relX = pixelX - 10'(`BOARD_X0);
	assign relY = pixelY - 9'(`BOARD_Y0);

	// left of or above the board wraps to a large value,
	// so one compare per axis covers both sides
	assign inBoard = (relX < 10'(BOARD_PIX)) && (relY < 9'(BOARD_PIX));

	assign col = relX[`SQUARE_SHIFT +: POS_BITS];
	assign row = relY[`SQUARE_SHIFT +: POS_BITS];
	assign offX = relX[`SQUARE_SHIFT-1:0];
	assign offY = relY[`SQUARE_SHIFT-1:0];

	assign centre = (offX >= `SQUARE_SHIFT'(CTR_LO)) && (offX < `SQUARE_SHIFT'(CTR_HI))
		&& (offY >= `SQUARE_SHIFT'(CTR_LO)) && (offY < `SQUARE_SHIFT'(CTR_HI));

	// index = row * 8 + col
	assign sq = squareCode'(displayBoard.squares[{row, col}]);

	always_comb begin
		baseColor = (row[0] ^ col[0]) ? `COLOR_DARK : `COLOR_LIGHT; // odd sum is dark
		case (sq)
			redMan: nextColor = `COLOR_RED;
			redKing: nextColor = `COLOR_RED;
			blackMan: nextColor = `COLOR_BLACKPIECE;
			blackKing: nextColor = `COLOR_BLACKPIECE;
			default: nextColor = baseColor; // empty and unused codes
		endcase
		if ((sq == redKing || sq == blackKing) && centre)
			nextColor = ~nextColor; // crown
		if (!inBoard)
			nextColor = `COLOR_BORDER;
	end

	// one cycle from coordinate to colour, new pixel every cycle
	always_ff @(posedge rst or posedge newData) begin
		if (newData)
			pixelColor <= `COLOR_BORDER;
		else
			pixelColor <= nextColor;
	end

endmodule

//--- design/boardStore.sv
`timescale 1ns/1ps

`include "checkers_consts.svh"

module boardStore (
	input logic rst,
	input logic newData,
	input logic sendValid,
	input logic sendReady,
	input checkersPkg::boardWord sendBoard,
	input logic rxValid,
	input checkersPkg::boardWord rxBoard,
	input logic showReceived,
	output checkersPkg::boardWord displayBoard,
	output logic boardUpdated
);
	import checkersPkg::*;

	boardWord localBoard; // last board this side sent
	boardWord remoteBoard; // last board off the wire
	logic accept;

	// same handshake the transmitter sees
	assign accept = sendValid & sendReady;

	always_ff @(posedge rst or posedge newData) begin
		if (newData) begin
			localBoard <= `TEST_BOARD; // something to look at before a send
			remoteBoard <= '0;
			boardUpdated <= 1'b0;
		end else begin
			if (accept)
				localBoard <= sendBoard;
			if (rxValid)
				remoteBoard <= rxBoard;
			boardUpdated <= rxValid; // high with the new board
		end
	end

	// no register here, the renderer holds the pipeline stage
	assign displayBoard = showReceived ? remoteBoard : localBoard;

endmodule

//--- design/checkersLinkTop.sv
`timescale 1ns/1ps

module checkersLinkTop (
	input logic rst,
	input logic newData,
	input logic sendValid,
	input checkersPkg::boardWord sendBoard,
	input logic linkClkIn,
	input logic linkDataIn,
	input logic linkFrameIn,
	input logic showReceived,
	input logic [9:0] pixelX,
	input logic [8:0] pixelY,
	output logic sendReady,
	output logic linkClkOut,
	output logic linkDataOut,
	output logic linkFrameOut,
	output logic boardUpdated,
	output logic [23:0] pixelColor
);
	import checkersPkg::*;

	logic rxValid; // one cycle, board complete
	boardWord rxBoard;
	boardWord displayBoard; // what the screen shows

	// outgoing link
	boardLinkTx tx (
		.rst(rst),
		.newData(newData),
		.sendValid(sendValid),
		.sendBoard(sendBoard),
		.sendReady(sendReady),
		.linkClkOut(linkClkOut),
		.linkDataOut(linkDataOut),
		.linkFrameOut(linkFrameOut)
	);

	// incoming link
	boardLinkRx rx (
		.rst(rst),
		.newData(newData),
		.linkClkIn(linkClkIn),
		.linkDataIn(linkDataIn),
		.linkFrameIn(linkFrameIn),
		.rxValid(rxValid),
		.rxBoard(rxBoard)
	);

	boardStore store (
		.rst(rst),
		.newData(newData),
		.sendValid(sendValid),
		.sendReady(sendReady), // store sees the same accept as tx
		.sendBoard(sendBoard),
		.rxValid(rxValid),
		.rxBoard(rxBoard),
		.showReceived(showReceived),
		.displayBoard(displayBoard),
		.boardUpdated(boardUpdated)
	);

	boardRender render (
		.rst(rst),
		.newData(newData),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.displayBoard(displayBoard),
		.pixelColor(pixelColor)
	);

endmodule

//--- design/checkersPkg.sv
package checkersPkg;

	`include "checkers_consts.svh"

	// what a single 4-bit square can hold
	typedef enum logic [`SQUARE_BITS-1:0] {
		empty     = 4'd0,
		redMan    = 4'd1,
		blackMan  = 4'd2,
		redKing   = 4'd3,
		blackKing = 4'd4
	} squareCode; // 5..15 unused, drawn as empty

	// one whole board in a single word
	// the link moves it row by row, the renderer picks single squares
	// row 0 sits in the low bits, square index = row * 8 + col
	typedef union packed {
		logic [`BOARD_ROWS-1:0][`BOARD_BITS/`BOARD_ROWS-1:0] rows; // link view
		logic [`BOARD_BITS/`SQUARE_BITS-1:0][`SQUARE_BITS-1:0] squares; // render view
	} boardWord;

endpackage

//--- files.f
+incdir+include
design/checkersPkg.sv
design/boardLinkTx.sv
design/boardLinkRx.sv
design/boardStore.sv
design/boardRender.sv
design/checkersLinkTop.sv
test/checkersLinkTb.sv

//--- include/checkers_consts.svh
`ifndef CHECKERS_CONSTS_SVH
`define CHECKERS_CONSTS_SVH

// board geometry, one row per 32-bit word
`define BOARD_BITS 256
`define BOARD_ROWS 8
`define SQUARE_BITS 4

// squares are 1 << SQUARE_SHIFT pixels on a side
`define SQUARE_SHIFT 5

// top left corner of the board on screen
`define BOARD_X0 192
`define BOARD_Y0 112

// 24-bit rgb
`define COLOR_LIGHT 24'hE8D0AA
`define COLOR_DARK 24'h7A4A26
`define COLOR_RED 24'hC81E1E
`define COLOR_BLACKPIECE 24'h202020
`define COLOR_BORDER 24'h304050

// opening position plus one king of each side, row 7 first
`define TEST_BOARD 256'h02020202_20202020_02020202_00400000_00000300_10101010_01010101_10101010

`endif

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the exit status is nonzero when the build fails or the testbench stops on $fatal
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module checkersLinkTb -f files.f -o simv &&
./obj_dir/simv || exit 1

//--- test/checkersLinkTb.sv
`timescale 1ns/1ps

`include "checkers_consts.svh"

module checkersLinkTb;
	import checkersPkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY = 5; // inputs change this long after the edge
	localparam int NUM_BOARDS = 6;
	localparam int NUM_PROBES = 20;
	localparam int SQ_PIX = 1 << `SQUARE_SHIFT;
	localparam int BOARD_PIX = `BOARD_ROWS * SQ_PIX;
	localparam int CENTRE_LO = (SQ_PIX - 16) / 2; // inner 16 pixels carry the crown
	localparam int READY_LOW_CYCLES = 2 * `BOARD_BITS + 2; // frame plus two
	localparam int CYCLES_PER_BOARD = 700;
	localparam int MARGIN_CYCLES = 400;

	logic rst;
	logic newData;
	logic sendValid;
	logic [`BOARD_BITS-1:0] sendBoard;
	logic showReceived;
	logic [9:0] pixelX;
	logic [8:0] pixelY;
	logic sendReady;
	logic linkClkOut;
	logic linkDataOut;
	logic linkFrameOut;
	logic boardUpdated;
	logic [23:0] pixelColor;

	// stimulus tables
	logic [`BOARD_BITS-1:0] boardTab [NUM_BOARDS];
	int probeX [NUM_PROBES];
	int probeY [NUM_PROBES];
	logic probeShow [NUM_PROBES];
	logic [23:0] probeColor [NUM_PROBES]; // hand worked from TEST_BOARD

	// model state
	logic [`BOARD_BITS-1:0] expLocal;
	logic [`BOARD_BITS-1:0] expRemote;
	logic [`BOARD_BITS-1:0] inFlight; // board currently on the wire
	logic pendValid; // a colour is due after the next edge
	logic [23:0] pendColor;
	int pendX;
	int pendY;
	int frameStarts; // rising edges seen on linkFrameOut
	logic frameSeen; // linkFrameOut one cycle ago
	int updates;
	integer seed;

	// link outputs wired straight back into the receiver
	checkersLinkTop u_dut (
		.rst(rst),
		.newData(newData),
		.sendValid(sendValid),
		.sendBoard(sendBoard),
		.linkClkIn(linkClkOut),
		.linkDataIn(linkDataOut),
		.linkFrameIn(linkFrameOut),
		.showReceived(showReceived),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.sendReady(sendReady),
		.linkClkOut(linkClkOut),
		.linkDataOut(linkDataOut),
		.linkFrameOut(linkFrameOut),
		.boardUpdated(boardUpdated),
		.pixelColor(pixelColor)
	);

	always #(CLK_PERIOD / 2) rst = ~rst;

	// every board gets its own budget, reset and probes share the margin
	initial begin
		#((NUM_BOARDS * CYCLES_PER_BOARD + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("Simulation failed");
		$fatal(1);
	end

	task checkValue(input string what, input logic [255:0] actual, input logic [255:0] expected);
		begin
			if (actual !== expected) begin
				$display("Error at time %0t: %s is %0h, expected %0h", $time, what, actual,
					expected);
				$display("Simulation failed");
				$fatal(1);
			end
		end
	endtask

	// colour rule worked out from coordinates, independent of the renderer
	function logic [23:0] expectedColor(input logic [`BOARD_BITS-1:0] board, input int x,
		input int y);
		int relX;
		int relY;
		int row;
		int col;
		int offX;
		int offY;
		squareCode code;
		logic [23:0] color;
		logic crown;
		begin
			relX = x - `BOARD_X0;
			relY = y - `BOARD_Y0;
			if (relX < 0 || relY < 0 || relX >= BOARD_PIX || relY >= BOARD_PIX)
				return `COLOR_BORDER;
			col = relX / SQ_PIX;
			row = relY / SQ_PIX;
			offX = relX % SQ_PIX;
			offY = relY % SQ_PIX;
			code = squareCode'(board[(row * `BOARD_ROWS + col) * `SQUARE_BITS +: `SQUARE_BITS]);
			case (code)
				redMan, redKing: color = `COLOR_RED;
				blackMan, blackKing: color = `COLOR_BLACKPIECE;
				default: color = ((row + col) % 2 == 0) ? `COLOR_LIGHT : `COLOR_DARK;
			endcase
			crown = (code == redKing) || (code == blackKing);
			if (crown && offX >= CENTRE_LO && offX < CENTRE_LO + 16
				&& offY >= CENTRE_LO && offY < CENTRE_LO + 16)
				color = ~color;
			return color;
		end
	endfunction

	function int squareX(input int sq, input int off);
		return `BOARD_X0 + (sq % `BOARD_ROWS) * SQ_PIX + off;
	endfunction

	function int squareY(input int sq, input int off);
		return `BOARD_Y0 + (sq / `BOARD_ROWS) * SQ_PIX + off;
	endfunction

	// edge, settle, then check what the edge produced
	task nextCycle;
		logic accepting;
		begin
			accepting = sendValid & sendReady; // handshake before the edge
			@(posedge rst);
			#DRIVE_DELAY;
			if (accepting) begin
				expLocal = sendBoard;
				inFlight = sendBoard;
			end
			if (linkFrameOut && !frameSeen)
				frameStarts++;
			frameSeen = linkFrameOut;
			if (pendValid)
				checkValue($sformatf("pixelColor at (%0d,%0d)", pendX, pendY),
					256'(pixelColor), 256'(pendColor));
			pendValid = 1'b0;
			if (boardUpdated) begin
				updates++;
				expRemote = inFlight; // loopback hands back what was sent
			end
		end
	endtask

	task presentPixel(input int x, input int y, input logic show, input logic [23:0] expected);
		begin
			pixelX = 10'(x);
			pixelY = 9'(y);
			showReceived = show;
			pendValid = 1'b1; // colour due one cycle later
			pendColor = expected;
			pendX = x;
			pendY = y;
		end
	endtask

	task presentModelPixel(input int x, input int y, input logic show);
		begin
			presentPixel(x, y, show, expectedColor(show ? expRemote : expLocal, x, y));
		end
	endtask

	task randomBoard(output logic [`BOARD_BITS-1:0] board);
		begin
			for (int w = 0; w < `BOARD_ROWS; w++)
				board[w * 32 +: 32] = $random(seed); // unused codes show up too
		end
	endtask

	task setProbe(input int idx, input int x, input int y, input logic show,
		input logic [23:0] color);
		begin
			probeX[idx] = x;
			probeY[idx] = y;
			probeShow[idx] = show;
			probeColor[idx] = color;
		end
	endtask

	task fillTables;
		begin
			boardTab[0] = {64{4'h3}}; // all red kings
			boardTab[1] = {32{8'h42}}; // black kings and men
			boardTab[2] = '0; // empty, parity only
			randomBoard(boardTab[3]);
			randomBoard(boardTab[4]);
			randomBoard(boardTab[5]);
			// outside the board
			setProbe(0, 0, 0, 1'b0, `COLOR_BORDER);
			setProbe(1, 191, 200, 1'b0, `COLOR_BORDER);
			setProbe(2, 448, 200, 1'b0, `COLOR_BORDER);
			setProbe(3, 300, 111, 1'b0, `COLOR_BORDER);
			setProbe(4, 300, 368, 1'b0, `COLOR_BORDER);
			setProbe(5, 1023, 511, 1'b0, `COLOR_BORDER);
			// corners and plain squares
			setProbe(6, 192, 112, 1'b0, `COLOR_LIGHT);
			setProbe(7, 447, 367, 1'b0, `COLOR_LIGHT);
			setProbe(8, 240, 128, 1'b0, `COLOR_RED); // row 0 col 1 red man
			setProbe(9, 240, 128, 1'b1, `COLOR_DARK); // received board still empty
			setProbe(10, 192, 112, 1'b1, `COLOR_LIGHT);
			// red king at row 3 col 2, crown edges at offsets 8 and 23
			setProbe(11, 272, 224, 1'b0, ~`COLOR_RED);
			setProbe(12, 258, 210, 1'b0, `COLOR_RED);
			setProbe(13, 263, 224, 1'b0, `COLOR_RED);
			setProbe(14, 264, 224, 1'b0, ~`COLOR_RED);
			setProbe(15, 279, 231, 1'b0, ~`COLOR_RED);
			setProbe(16, 272, 232, 1'b0, `COLOR_RED);
			setProbe(17, 368, 256, 1'b0, ~`COLOR_BLACKPIECE); // black king row 4 col 5
			setProbe(18, 200, 277, 1'b0, `COLOR_BLACKPIECE); // black man row 5 col 0
			setProbe(19, 232, 240, 1'b0, `COLOR_DARK); // row 4 col 1 empty
		end
	endtask

	task checkResetState;
		begin
			checkValue("sendReady after reset", 256'(sendReady), 256'(1));
			checkValue("linkClkOut after reset", 256'(linkClkOut), 256'(0));
			checkValue("linkDataOut after reset", 256'(linkDataOut), 256'(0));
			checkValue("linkFrameOut after reset", 256'(linkFrameOut), 256'(0));
			checkValue("boardUpdated after reset", 256'(boardUpdated), 256'(0));
			checkValue("pixelColor after reset", 256'(pixelColor), 256'(`COLOR_BORDER));
		end
	endtask

	task runProbeTable;
		begin
			for (int p = 0; p < NUM_PROBES; p++) begin
				presentPixel(probeX[p], probeY[p], probeShow[p], probeColor[p]);
				nextCycle();
			end
		end
	endtask

	// centre of each square from the received board, a corner from the local one
	task sweepSquares;
		begin
			for (int s = 0; s < `BOARD_ROWS * `BOARD_ROWS; s++) begin
				presentModelPixel(squareX(s, SQ_PIX / 2), squareY(s, SQ_PIX / 2), 1'b1);
				nextCycle();
				presentModelPixel(squareX(s, 1), squareY(s, SQ_PIX - 2), 1'b0);
				nextCycle();
			end
		end
	endtask

	// send with valid held through busy, pixels stream every cycle meanwhile
	task sendAndStream(input logic [`BOARD_BITS-1:0] board);
		int lowCycles;
		int framesBefore;
		int updatesBefore;
		int sq;
		int offX;
		int offY;
		logic done;
		begin
			lowCycles = 0;
			framesBefore = frameStarts;
			updatesBefore = updates;
			done = 1'b0;
			checkValue("sendReady before a send", 256'(sendReady), 256'(1));
			sendBoard = board;
			sendValid = 1'b1;
			presentModelPixel(squareX(0, 0), squareY(0, 0), 1'b0);
			while (!done) begin
				nextCycle();
				if (sendReady) begin
					done = 1'b1;
				end else begin
					lowCycles++;
					if (lowCycles == 1)
						checkValue("linkFrameOut after accept", 256'(linkFrameOut), 256'(1));
					if (lowCycles > 2 * READY_LOW_CYCLES) begin
						$display("sendReady stayed low far longer than one frame");
						$display("Simulation failed");
						$fatal(1);
					end
					sq = $random(seed) & 63;
					offX = $random(seed) & 31;
					offY = $random(seed) & 31;
					if (lowCycles % 8 == 0) begin // anywhere on screen, border included
						offX = $random(seed) & 32'h3ff;
						offY = $random(seed) & 32'h1ff;
						presentModelPixel(offX, offY, lowCycles[6]);
					end else begin
						presentModelPixel(squareX(sq, offX), squareY(sq, offY), lowCycles[6]);
					end
				end
			end
			checkValue("cycles with sendReady low", 256'(lowCycles), 256'(READY_LOW_CYCLES));
			checkValue("frames started", 256'(frameStarts - framesBefore), 256'(1));
			checkValue("boardUpdated pulses", 256'(updates - updatesBefore), 256'(1));
			checkValue("linkFrameOut after the frame", 256'(linkFrameOut), 256'(0));
			checkValue("linkClkOut after the frame", 256'(linkClkOut), 256'(0));
			sendValid = 1'b0; // dropped before the edge that could accept again
			presentModelPixel(squareX(9, 16), squareY(9, 16), 1'b0);
			nextCycle();
			checkValue("sendReady after the send", 256'(sendReady), 256'(1));
			checkValue("frames started after the send", 256'(frameStarts - framesBefore),
				256'(1));
		end
	endtask

	initial begin
		rst = 1'b0;
		newData = 1'b1;
		sendValid = 1'b0;
		sendBoard = '0;
		showReceived = 1'b0;
		pixelX = '0;
		pixelY = '0;
		seed = 51060;
		frameStarts = 0;
		frameSeen = 1'b0;
		updates = 0;
		pendValid = 1'b0;
		pendColor = '0;
		pendX = 0;
		pendY = 0;
		expLocal = `TEST_BOARD;
		expRemote = '0;
		inFlight = '0;
		fillTables();
		repeat (RESET_CYCLES) nextCycle();
		newData = 1'b0;
		checkResetState();
		runProbeTable();
		sweepSquares(); // TEST_BOARD locally, empty received board
		for (int k = 0; k < NUM_BOARDS; k++) begin
			sendAndStream(boardTab[k]);
			sweepSquares();
		end
		nextCycle(); // last colour still in flight
		$display("Simulation passed");
		$finish;
	end

endmodule
